// File: Makefile
# Verilator simulation of the interpolation wrapper

TOP             ?= tb_interp_top
FLIST           ?= flist.f
LOG             ?= sim.log
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP FLIST LOG BUILD_DIR VERILATOR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
hdl/interp_pkg.sv
hdl/quad_tap.sv
hdl/quad_interp_core.sv
hdl/frame_delay.sv
hdl/interp_top.sv
tb/tb_clock_gen.sv
tb/interp_checker.sv
tb/tb_interp_top.sv

// File: hdl/frame_delay.sv
`timescale 1ns/1ps
`default_nettype none

module frame_delay
(
   input  wire                                              clk,
   input  wire                                              rst_n,
   input  wire                                              load,
   input  wire interp_pkg::result_t [interp_pkg::N_OUT-1:0] results,
   output wire interp_pkg::result_t [interp_pkg::N_OUT-1:0] held
);

   import interp_pkg::*;

   result_t [N_OUT-1:0] stage_q [CHAIN_DEPTH];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Strobe-gated chain
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < CHAIN_DEPTH; s++)
         begin
            stage_q[s] <= '0;
         end
      end
      else if (load)
      begin
         stage_q[0] <= results;
         for (int s = 1; s < CHAIN_DEPTH; s++)
         begin
            stage_q[s] <= stage_q[s-1];
         end
      end
   end

   assign held = stage_q[CHAIN_DEPTH-1];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Core outputs move only once the tap pipeline has drained
   results_settle: assert property (@(posedge clk) disable iff (!rst_n)
      !$stable(results) |-> $past(load, TAP_LAT + 1))
      else $error("results changed outside the tap latency slot");

endmodule

`default_nettype wire

// File: hdl/interp_pkg.sv
`default_nettype none

package interp_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int SAMPLE_W = 8;
   localparam int RESULT_W = 9;
   localparam int OUT_W    = 16;

   // Frame geometry
   localparam int N_IN   = 11;
   localparam int N_OUT  = 2 * N_IN - 1;
   localparam int N_TAPS = N_IN - 1;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Timing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Register stages inside one tap
   localparam int TAP_LAT      = 3;
   // Strobe-gated stages after the core
   localparam int CHAIN_DEPTH  = 3;
   localparam int MIN_LOAD_GAP = 4;
   // Wide enough to hold MIN_LOAD_GAP
   localparam int GAP_CNT_W    = $clog2(MIN_LOAD_GAP + 1);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Data types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [RESULT_W-1:0] result_t;
   typedef logic signed [OUT_W-1:0]    out_t;

endpackage

`default_nettype wire

// File: hdl/interp_top.sv
`timescale 1ns/1ps
`default_nettype none

module interp_top
(
   input  wire                                             clk,
   input  wire                                             rst_n,
   input  wire                                             load,
   input  wire interp_pkg::sample_t [interp_pkg::N_IN-1:0] samples,
   output wire interp_pkg::out_t [interp_pkg::N_OUT-1:0]   dout
);

   import interp_pkg::*;

   wire result_t [N_OUT-1:0] results;
   wire result_t [N_OUT-1:0] held;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Producer and buffer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   quad_interp_core i_core
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (load),
      .samples (samples),
      .results (results)
   );

   frame_delay i_delay
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (load),
      .results (results),
      .held    (held)
   );

   // Widen to the port width
   for (genvar i = 0; i < N_OUT; i++)
   begin : g_sext
      assign dout[i] = out_t'(held[i]);
   end

endmodule

`default_nettype wire

// File: hdl/quad_interp_core.sv
`timescale 1ns/1ps
`default_nettype none

module quad_interp_core
(
   input  wire                                              clk,
   input  wire                                              rst_n,
   input  wire                                              load,
   input  wire interp_pkg::sample_t [interp_pkg::N_IN-1:0]  samples,
   output wire interp_pkg::result_t [interp_pkg::N_OUT-1:0] results
);

   import interp_pkg::*;

   sample_t [N_IN-1:0]   smp_q;
   result_t [N_IN-1:0]   even_q [TAP_LAT];
   logic [GAP_CNT_W-1:0] gap_cnt;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Frame capture
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         smp_q <= '0;
      end
      else if (load)
      begin
         smp_q <= samples;
      end
   end

   // Even path, matched to the tap latency
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < TAP_LAT; s++)
         begin
            even_q[s] <= '0;
         end
      end
      else
      begin
         for (int k = 0; k < N_IN; k++)
         begin
            even_q[0][k] <= result_t'(smp_q[k]);
         end
         for (int s = 1; s < TAP_LAT; s++)
         begin
            even_q[s] <= even_q[s-1];
         end
      end
   end

   for (genvar i = 0; i < N_IN; i++)
   begin : g_even
      assign results[2*i] = even_q[TAP_LAT-1][i];
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Odd taps
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   for (genvar k = 0; k < N_TAPS; k++)
   begin : g_tap
      if (k < N_TAPS - 1)
      begin : g_fwd
         quad_tap i_tap
         (
            .clk   (clk),
            .rst_n (rst_n),
            .near  (smp_q[k]),
            .mid   (smp_q[k+1]),
            .far   (smp_q[k+2]),
            .point (results[2*k+1])
         );
      end
      else
      begin : g_mirror
         // Last gap has no right neighbour, so look back into the frame
         quad_tap i_tap
         (
            .clk   (clk),
            .rst_n (rst_n),
            .near  (smp_q[N_IN-1]),
            .mid   (smp_q[N_IN-2]),
            .far   (smp_q[N_IN-3]),
            .point (results[2*k+1])
         );
      end
   end

   // Cycles since the last load, saturating
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         gap_cnt <= GAP_CNT_W'(MIN_LOAD_GAP);
      end
      else if (load)
      begin
         gap_cnt <= GAP_CNT_W'(1);
      end
      else if (gap_cnt < GAP_CNT_W'(MIN_LOAD_GAP))
      begin
         gap_cnt <= gap_cnt + 1'b1;
      end
   end

   load_spacing: assert property (@(posedge clk) disable iff (!rst_n)
      load |-> gap_cnt >= GAP_CNT_W'(MIN_LOAD_GAP))
      else $error("load strobes closer than %0d cycles", MIN_LOAD_GAP);

endmodule

`default_nettype wire

// File: hdl/quad_tap.sv
`timescale 1ns/1ps
`default_nettype none

module quad_tap
(
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire interp_pkg::sample_t near,
   input  wire interp_pkg::sample_t mid,
   input  wire interp_pkg::sample_t far,
   output interp_pkg::result_t point
);

   import interp_pkg::*;

   // Stage 1 weighted terms
   sample_t near_t;
   sample_t mid_t;
   sample_t far_t;

   // Stage 2 partial sum and the far term carried along
   result_t sum_q;
   sample_t far_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stage 1
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // 3/8 near, 3/4 mid, 1/8 far, all truncating
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         near_t <= '0;
         mid_t  <= '0;
         far_t  <= '0;
      end
      else
      begin
         near_t <= (near >>> 2) + (near >>> 3);
         mid_t  <= (mid >>> 1) + (mid >>> 2);
         far_t  <= far >>> 3;
      end
   end

   // Stage 2
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         sum_q <= '0;
         far_q <= '0;
      end
      else
      begin
         sum_q <= result_t'(near_t) + result_t'(mid_t);
         far_q <= far_t;
      end
   end

   // Stage 3 subtracts the far term
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         point <= '0;
      end
      else
      begin
         point <= sum_q - result_t'(far_q);
      end
   end

endmodule

`default_nettype wire

// File: tb/interp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module interp_checker
(
   input  wire                                              clk,
   input  wire                                              rst_n,
   input  wire                                              load,
   input  wire                                              finish,
   input  wire [7:0]                                        test_id,
   input  wire interp_pkg::result_t [interp_pkg::N_OUT-1:0] expected,
   input  wire interp_pkg::out_t [interp_pkg::N_OUT-1:0]    dout,
   output int                                               errors,
   output int                                               checks,
   output int                                               tests_passed,
   output int                                               tests_failed,
   output logic                                             report_done
);

   import interp_pkg::*;

   // Outputs are sampled this long after the rising edge
   localparam int SETTLE_NS = 2;

   result_t [N_OUT-1:0] frame_q [$];
   result_t [N_OUT-1:0] old_frame;
   out_t [N_OUT-1:0]    want;
   out_t [N_OUT-1:0]    last_dout = '0;
   logic [7:0]          cur_test = 8'd0;
   int                  err_cnt = 0;
   int                  chk_cnt = 0;
   int                  pass_cnt = 0;
   int                  fail_cnt = 0;
   int                  test_errors = 0;
   int                  test_checks = 0;
   logic                done_q = 1'b0;
   logic                load_seen;
   logic                finish_seen;

   assign errors       = err_cnt;
   assign checks       = chk_cnt;
   assign tests_passed = pass_cnt;
   assign tests_failed = fail_cnt;
   assign report_done  = done_q;

   task automatic report_test();
      if (test_errors == 0 && test_checks > 0)
      begin
         pass_cnt++;
         $display("Test %0d: %0d checks, passed", cur_test, test_checks);
      end
      else
      begin
         fail_cnt++;
         $display("Test %0d: %0d checks, %0d errors, failed", cur_test, test_checks,
                  test_errors);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Compare after each edge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge clk)
   begin
      load_seen   = rst_n && load;
      finish_seen = finish;
      #(SETTLE_NS);
      if (finish_seen)
      begin
         if (cur_test != 8'd0)
         begin
            report_test();
         end
         done_q = 1'b1;
      end
      else if (load_seen)
      begin
         // Flush loads count toward the last real test
         if (test_id != 8'd0 && test_id != cur_test)
         begin
            if (cur_test != 8'd0)
            begin
               report_test();
            end
            cur_test    = test_id;
            test_errors = 0;
            test_checks = 0;
         end
         frame_q.push_back(expected);
         want = '0;
         if (frame_q.size() > CHAIN_DEPTH)
         begin
            old_frame = frame_q.pop_front();
            for (int i = 0; i < N_OUT; i++)
            begin
               want[i] = out_t'(old_frame[i]);
            end
         end
         for (int i = 0; i < N_OUT; i++)
         begin
            chk_cnt++;
            test_checks++;
            if (dout[i] !== want[i])
            begin
               err_cnt++;
               test_errors++;
               $display("Mismatch at %0d ns: dout[%0d] expected %0d actual %0d",
                        $time, i, want[i], dout[i]);
            end
         end
      end
      else if (rst_n)
      begin
         // No strobe, so nothing may move
         for (int i = 0; i < N_OUT; i++)
         begin
            if (dout[i] !== last_dout[i])
            begin
               err_cnt++;
               test_errors++;
               $display("Mismatch at %0d ns: dout[%0d] expected %0d actual %0d without a load",
                        $time, i, last_dout[i], dout[i]);
            end
         end
      end
      last_dout = dout;
   end

endmodule

`default_nettype wire

// File: tb/interp_testdata.hex
// Per frame: test id, gap (0 = random 4..7), samples 0..10,
// then expected results 0..20 as 9-bit two's complement
01 0000 00 0a 14 1e 28 32 3c 46 50 5a 64
000 005 00a 00f 014 018 01e 022 028 02d 032 037 03c 040 046 04a 050 055 05a 05e 064
01 0000 f9 f9 f9 f9 f9 f9 f9 f9 f9 f9 f9
1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9
01 0000 80 80 80 80 80 80 80 80 80 80 80
180 180 180 180 180 180 180 180 180 180 180 180 180 180 180 180 180 180 180 180 180
// Extreme sample values
02 0000 80 7f 80 7f 80 7f 80 7f 80 7f 80
180 03e 07f 1bf 180 03e 07f 1bf 180 03e 07f 1bf 180 03e 07f 1bf 180 03e 07f 03e 180
02 0000 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
07f 07d 07f 07d 07f 07d 07f 07d 07f 07d 07f 07d 07f 07d 07f 07d 07f 07d 07f 07d 07f
// Ramp, alternating sign, constant
03 0000 ce d8 e2 ec f6 00 0a 14 1e 28 32
1ce 1d2 1d8 1dd 1e2 1e7 1ec 1f0 1f6 1fa 000 005 00a 00f 014 018 01e 022 028 02d 032
03 0000 14 ec 14 ec 14 ec 14 ec 14 ec 14
014 1f6 1ec 00a 014 1f6 1ec 00a 014 1f6 1ec 00a 014 1f6 1ec 00a 014 1f6 1ec 1f6 014
03 0000 64 64 64 64 64 64 64 64 64 64 64
064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 064
// Mirrored last gap
04 0000 00 00 00 00 00 00 00 00 80 00 7f
000 000 000 000 000 000 000 000 000 000 000 000 000 010 000 1a0 180 1c1 000 03e 07f
04 0000 00 00 00 00 00 00 00 00 7f 00 80
000 000 000 000 000 000 000 000 000 000 000 000 000 1f1 000 05e 07f 03e 000 1c1 180
// Loads at the minimum spacing
05 0004 00 0a 14 1e 28 32 3c 46 50 5a 64
000 005 00a 00f 014 018 01e 022 028 02d 032 037 03c 040 046 04a 050 055 05a 05e 064
05 0004 14 ec 14 ec 14 ec 14 ec 14 ec 14
014 1f6 1ec 00a 014 1f6 1ec 00a 014 1f6 1ec 00a 014 1f6 1ec 00a 014 1f6 1ec 1f6 014
05 0004 80 7f 80 7f 80 7f 80 7f 80 7f 80
180 03e 07f 1bf 180 03e 07f 1bf 180 03e 07f 1bf 180 03e 07f 1bf 180 03e 07f 03e 180
// Long gaps while the samples keep changing
06 0008 ce d8 e2 ec f6 00 0a 14 1e 28 32
1ce 1d2 1d8 1dd 1e2 1e7 1ec 1f0 1f6 1fa 000 005 00a 00f 014 018 01e 022 028 02d 032
06 0008 00 00 00 00 00 00 00 00 80 00 7f
000 000 000 000 000 000 000 000 000 000 000 000 000 010 000 1a0 180 1c1 000 03e 07f
06 0008 f9 f9 f9 f9 f9 f9 f9 f9 f9 f9 f9
1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9 1f8 1f9

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 16,
   parameter int DELAY_NS     = 1
)
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release just after an edge, like the other stimulus
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #(DELAY_NS) rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: tb/tb_interp_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_interp_top;

   import interp_pkg::*;

   localparam int WORDS_PER_FRAME = 2 + N_IN + N_OUT;
   localparam int MAX_FRAMES      = 16;
   localparam int CLK_NS          = 8;
   localparam int RESET_CYCLES    = 16;
   localparam int DRIVE_DELAY_NS  = 1;
   localparam int MARGIN_NS       = 200;
   localparam int MAX_EXTRA_IDLE  = 3;

   logic                clk;
   logic                rst_n;
   logic                load;
   logic                finish;
   logic [7:0]          test_id;
   sample_t [N_IN-1:0]  samples;
   result_t [N_OUT-1:0] expected;
   out_t [N_OUT-1:0]    dout;
   int                  errors;
   int                  checks;
   int                  tests_passed;
   int                  tests_failed;
   logic                report_done;

   logic [15:0] mem [0:(MAX_FRAMES+1)*WORDS_PER_FRAME-1];
   logic [31:0] lcg_state;
   int          n_frames;
   int          max_gap;
   int          limit_ns;
   int          base;

   tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RESET_CYCLES),
                  .DELAY_NS(DRIVE_DELAY_NS)) i_clock
   (
      .clk   (clk),
      .rst_n (rst_n)
   );

   interp_top i_interp_top
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (load),
      .samples (samples),
      .dout    (dout)
   );

   interp_checker i_checker
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .load         (load),
      .finish       (finish),
      .test_id      (test_id),
      .expected     (expected),
      .dout         (dout),
      .errors       (errors),
      .checks       (checks),
      .tests_passed (tests_passed),
      .tests_failed (tests_failed),
      .report_done  (report_done)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // One strobe, then idle cycles with scrambled samples
   task automatic apply_frame(input logic [7:0] id, input int gap,
                              input sample_t [N_IN-1:0] smp,
                              input result_t [N_OUT-1:0] exp_res);
      int idle;
      idle = gap;
      if (gap == 0)
      begin
         lcg_state = lcg_next(lcg_state);
         idle = MIN_LOAD_GAP + int'((lcg_state >> 16) & 32'd3);
      end
      samples  = smp;
      expected = exp_res;
      test_id  = id;
      load     = 1'b1;
      @(posedge clk);
      #(DRIVE_DELAY_NS);
      load = 1'b0;
      for (int c = 1; c < idle; c++)
      begin
         lcg_state = lcg_next(lcg_state);
         for (int k = 0; k < N_IN; k++)
         begin
            samples[k] = sample_t'(lcg_state[31:24] ^ 8'(k * 37));
         end
         @(posedge clk);
         #(DRIVE_DELAY_NS);
      end
   endtask

   task automatic play_file_frame(input int f);
      sample_t [N_IN-1:0]  smp;
      result_t [N_OUT-1:0] exp_res;
      base = f * WORDS_PER_FRAME;
      for (int k = 0; k < N_IN; k++)
      begin
         smp[k] = sample_t'(mem[base+2+k][7:0]);
      end
      for (int i = 0; i < N_OUT; i++)
      begin
         exp_res[i] = result_t'(mem[base+2+N_IN+i][8:0]);
      end
      apply_frame(mem[base][7:0], int'(mem[base+1]), smp, exp_res);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial
   begin
      load      = 1'b0;
      finish    = 1'b0;
      test_id   = 8'd0;
      samples   = '0;
      expected  = '0;
      lcg_state = 32'hc6b3;
      limit_ns  = 0;
      n_frames  = 0;
      max_gap   = MIN_LOAD_GAP;
      for (int w = 0; w < (MAX_FRAMES + 1) * WORDS_PER_FRAME; w++)
      begin
         mem[w] = 16'h0;
      end
      $readmemh("tb/interp_testdata.hex", mem);

      // Test id zero ends the table
      while (n_frames < MAX_FRAMES && mem[n_frames*WORDS_PER_FRAME] != 16'h0)
      begin
         base = n_frames * WORDS_PER_FRAME;
         if (mem[base+1] == 16'h0)
         begin
            max_gap = (max_gap > MIN_LOAD_GAP + MAX_EXTRA_IDLE) ? max_gap
                      : MIN_LOAD_GAP + MAX_EXTRA_IDLE;
         end
         else if (int'(mem[base+1]) > max_gap)
         begin
            max_gap = int'(mem[base+1]);
         end
         n_frames++;
      end
      limit_ns = (n_frames + CHAIN_DEPTH) * (max_gap + 3) * CLK_NS
                 + RESET_CYCLES * CLK_NS + MARGIN_NS;

      wait (rst_n === 1'b1);
      @(posedge clk);
      #(DRIVE_DELAY_NS);
      for (int f = 0; f < n_frames; f++)
      begin
         play_file_frame(f);
      end
      // Push the last frames out of the chain
      for (int j = 0; j < CHAIN_DEPTH; j++)
      begin
         apply_frame(8'd0, MIN_LOAD_GAP, '0, '0);
      end

      finish = 1'b1;
      @(posedge clk);
      #(DRIVE_DELAY_NS);
      finish = 1'b0;
      wait (report_done === 1'b1);
      $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
               tests_passed, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0 && n_frames > 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog
   initial
   begin
      wait (limit_ns > 0);
      #(limit_ns);
      $display("Run timed out after %0d ns before all frames were checked", limit_ns);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
